// ==== list.f ====
+incdir+hw
hw/fb_pkg.sv
hw/line_buffer.sv
hw/line_fetch.sv
hw/page_write.sv
hw/burst_arbiter.sv
hw/frame_buffer_top.sv
tests/tb_clock_gen.sv
tests/frame_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: frame_buffer

sources:
  - include_dirs:
      - hw
    files:
      - hw/fb_pkg.sv
      - hw/line_buffer.sv
      - hw/line_fetch.sv
      - hw/page_write.sv
      - hw/burst_arbiter.sv
      - hw/frame_buffer_top.sv
      - target: test
        files:
          - tests/tb_clock_gen.sv
          - tests/frame_buffer_tb.sv

// ==== tests/frame_buffer_tb.sv ====
`timescale 1ns/10ps
`include "fb_cfg.svh"

module frame_buffer_tb;
  import fb_pkg::*;

  localparam logic [31:0]           SEED      = 32'h5786_589c;
  localparam int                    TIMEOUT   = 20000;  // cycles per wait
  localparam logic [`FB_LINE_W-1:0] LINE_L    = 12'h02a;
  localparam logic [`FB_LINE_W-1:0] LINE_M    = 12'h135;
  localparam logic [`FB_LINE_W-1:0] LINE_N    = 12'h2d0;
  localparam logic [`FB_PAGE_W-1:0] PAGE_A    = 14'h00aa;  // inside line L
  localparam logic [`FB_PAGE_W-1:0] PAGE_B    = 14'h0b47;  // next to line N
  localparam logic [`FB_ADDR_W-1:0] HOST_ADDR = {12'h135, 10'h37f};

  logic                      sdram_clk;
  logic                      sys_rst_n;
  line_req_t                 line_req;
  logic                      line_ack;
  page_req_t                 page_req;
  logic                      page_ack;
  stage_wr_t                 stage_wr;
  host_wr_t                  host_wr;
  logic                      host_ack;
  logic [`FB_PIX_ADDR_W-1:0] pix_addr;
  pixel_t                    pix_a_data;
  pixel_t                    pix_b_data;
  mem_req_t                  mem_req;
  logic                      mem_ack;
  pixel_t                    mem_wdata;
  pixel_t                    mem_rdata;
  logic                      busy;

  string       test_name = "reset";
  pixel_t      model_mem [int unsigned];  // sparse sdram contents
  mem_req_t    burst_log [$];             // every burst in start order
  pixel_t      staged [`FB_BURST_LEN];
  logic [31:0] gap_lfsr  = SEED;
  logic [31:0] data_lfsr = SEED;

  tb_clock_gen #(.PERIOD(20), .RST_CYCLES(16)) clock_gen_inst (
    .sdram_clk (sdram_clk),
    .sys_rst_n (sys_rst_n)
  );

  frame_buffer_top frame_buffer_top_inst (
    .sdram_clk  (sdram_clk),
    .sys_rst_n  (sys_rst_n),
    .line_req   (line_req),
    .line_ack   (line_ack),
    .page_req   (page_req),
    .page_ack   (page_ack),
    .stage_wr   (stage_wr),
    .host_wr    (host_wr),
    .host_ack   (host_ack),
    .pix_addr   (pix_addr),
    .pix_a_data (pix_a_data),
    .pix_b_data (pix_b_data),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .busy       (busy)
  );

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic pixel_t model_read(int unsigned addr);
    if (model_mem.exists(addr)) begin
      return model_mem[addr];
    end
    return addr[15:0] ^ 16'ha5a5;  // unwritten word pattern
  endfunction

  task automatic fail_now(string msg);
    $display("TEST FAIL");
    $display("%s", msg);
    $fatal(1);
  endtask

  task automatic check_eq(string what, logic [63:0] exp, logic [63:0] act);
    assert (exp === act) else
      fail_now($sformatf("error %s %s: expected %0h, actual %0h", test_name, what, exp, act));
  endtask

  task automatic rand_word(output pixel_t w);
    for (int b = 0; b < 16; b++) begin
      w[b] = data_lfsr[0];
      data_lfsr = lfsr_step(data_lfsr);
    end
  endtask

  // 0 line, 1 page, 2 host
  task automatic wait_ack(int which, logic level, string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = ~level;
    while (seen !== level) begin
      @(posedge sdram_clk);
      case (which)
        0:       seen = line_ack;
        1:       seen = page_ack;
        default: seen = host_ack;
      endcase
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_now($sformatf("timeout waiting for %s during %s", what, test_name));
      end
    end
  endtask

  // controller model behind the burst port
  initial begin
    mem_req_t cur;
    mem_req_t req_s;
    logic     ack_s;
    pixel_t   wdata_s;
    logic     busy_s;
    logic     in_burst;
    logic     drop_due;
    int       count;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    in_burst  = 1'b0;
    drop_due  = 1'b0;
    count     = 0;
    forever begin
      @(posedge sdram_clk);
      req_s   = mem_req;
      ack_s   = mem_ack;
      wdata_s = mem_wdata;
      busy_s  = busy;
      if (sys_rst_n) begin
        if (req_s.valid) begin
          check_eq("busy during burst", 1, busy_s);
        end
        if (drop_due) begin
          check_eq("valid after last ack", 0, req_s.valid);
          drop_due = 1'b0;
        end else if (in_burst) begin
          check_eq("burst request held", cur, req_s);  // also catches interleaving
          if (ack_s) begin
            if (cur.write) begin
              model_mem[cur.addr + count] = wdata_s;
            end
            count++;
            if (count == cur.len) begin
              in_burst = 1'b0;
              drop_due = 1'b1;
            end
          end
        end else if (req_s.valid) begin
          cur      = req_s;
          count    = 0;
          in_burst = 1'b1;
          burst_log.push_back(req_s);
        end
      end
      #1;
      if (in_burst) begin
        mem_ack   = ~gap_lfsr[0];  // one lfsr bit per cycle decides the gap
        gap_lfsr  = lfsr_step(gap_lfsr);
        mem_rdata = cur.write ? '0 : model_read(cur.addr + count);
      end else begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
      end
    end
  end

  task automatic check_idle_outputs();
    check_eq("mem_req valid", 0, mem_req.valid);
    check_eq("line_ack", 0, line_ack);
    check_eq("page_ack", 0, page_ack);
    check_eq("host_ack", 0, host_ack);
    check_eq("busy", 0, busy);
  endtask

  task automatic check_reset();
    int cycles;
    cycles = 0;
    while (sys_rst_n !== 1'b1) begin
      @(posedge sdram_clk);
      check_idle_outputs();
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_now("reset was never released");
      end
    end
    for (int i = 0; i < 4; i++) begin
      @(posedge sdram_clk);
      check_idle_outputs();
    end
  endtask

  task automatic write_host_word(logic [`FB_ADDR_W-1:0] waddr, pixel_t wdata);
    #1 host_wr = '{req: 1'b1, addr: waddr, data: wdata};
    wait_ack(2, 1'b1, "host_ack rise");
    #1 host_wr.req = 1'b0;
    wait_ack(2, 1'b0, "host_ack fall");
  endtask

  task automatic load_staging();
    pixel_t w;
    for (int i = 0; i < `FB_BURST_LEN; i++) begin
      @(posedge sdram_clk);
      rand_word(w);
      staged[i] = w;
      #1 stage_wr = '{en: 1'b1, idx: 8'(i), data: w};
    end
    @(posedge sdram_clk);
    #1 stage_wr.en = 1'b0;
  endtask

  task automatic request_line(logic [`FB_LINE_W-1:0] num, logic to_a);
    @(posedge sdram_clk);
    #1 line_req = '{req: 1'b1, line: num, buf_a: to_a};
    wait_ack(0, 1'b1, "line_ack rise");
    #1 line_req.req = 1'b0;
    wait_ack(0, 1'b0, "line_ack fall");
  endtask

  task automatic request_page(logic [`FB_PAGE_W-1:0] num);
    @(posedge sdram_clk);
    #1 page_req = '{req: 1'b1, page: num};
    wait_ack(1, 1'b1, "page_ack rise");
    #1 page_req.req = 1'b0;
    wait_ack(1, 1'b0, "page_ack fall");
  endtask

  task automatic check_page_burst(int first, logic [`FB_PAGE_W-1:0] num);
    int          writes;
    int unsigned base;
    mem_req_t    b;
    writes = 0;
    base   = int'(num) << 8;
    for (int k = first; k < burst_log.size(); k++) begin
      b = burst_log[k];
      if (b.write) begin
        writes++;
        check_eq("page burst address", base, b.addr);
        check_eq("page burst length", `FB_BURST_LEN, b.len);
      end
    end
    check_eq("page write bursts", 1, writes);
    for (int i = 0; i < `FB_BURST_LEN; i++) begin
      check_eq($sformatf("page word %0d", i), staged[i], model_read(base + i));
    end
  endtask

  // data shows up one cycle after the edge that takes pix_addr
  task automatic compare_lines(logic [`FB_LINE_W-1:0] line_a, logic [`FB_LINE_W-1:0] line_b);
    int unsigned base_a;
    int unsigned base_b;
    base_a = int'(line_a) << 10;
    base_b = int'(line_b) << 10;
    for (int i = 0; i < 1026; i++) begin
      @(posedge sdram_clk);
      if (i >= 2) begin
        check_eq($sformatf("buffer a pixel %0d", i - 2), model_read(base_a + i - 2), pix_a_data);
        check_eq($sformatf("buffer b pixel %0d", i - 2), model_read(base_b + i - 2), pix_b_data);
      end
      #1;
      if (i < 1024) begin
        pix_addr = 10'(i);
      end
    end
  endtask

  initial begin
    int first;
    line_req = '0;
    page_req = '0;
    stage_wr = '0;
    host_wr  = '0;
    pix_addr = '0;
    check_reset();

    test_name = "single write";
    first = burst_log.size();
    write_host_word(HOST_ADDR, 16'h3c5e);
    check_eq("bursts per host write", 1, burst_log.size() - first);
    check_eq("host burst", {1'b1, 1'b1, HOST_ADDR, 9'd1}, burst_log[first]);
    check_eq("host word in memory", 16'h3c5e, model_read(HOST_ADDR));

    test_name = "dma page write";
    load_staging();
    first = burst_log.size();
    request_page(PAGE_A);
    check_eq("bursts per page", 1, burst_log.size() - first);
    check_page_burst(first, PAGE_A);

    test_name = "line fetch";
    request_line(LINE_L, 1'b1);
    request_line(LINE_M, 1'b0);  // line m also holds the host word
    compare_lines(LINE_L, LINE_M);

    test_name = "arbitration";
    load_staging();
    first = burst_log.size();
    @(posedge sdram_clk);
    #1;
    line_req = '{req: 1'b1, line: LINE_N, buf_a: 1'b1};
    page_req = '{req: 1'b1, page: PAGE_B};  // same cycle as the line request
    wait_ack(0, 1'b1, "line_ack rise");
    #1 line_req.req = 1'b0;
    wait_ack(0, 1'b0, "line_ack fall");
    wait_ack(1, 1'b1, "page_ack rise");
    #1 page_req.req = 1'b0;
    wait_ack(1, 1'b0, "page_ack fall");
    check_eq("bursts in race", 5, burst_log.size() - first);
    check_eq("first burst is a read", 0, burst_log[first].write);
    check_page_burst(first, PAGE_B);
    compare_lines(LINE_N, LINE_M);

    @(posedge sdram_clk);
    check_eq("busy when idle", 0, busy);
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 16
) (
  output logic sdram_clk,
  output logic sys_rst_n
);

  initial begin
    sdram_clk = 1'b0;
    forever #(PERIOD / 2) sdram_clk = ~sdram_clk;
  end

  initial begin
    sys_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge sdram_clk);
    #1 sys_rst_n = 1'b1;  // release just after an edge
  end

endmodule

// ==== hw/frame_buffer_top.sv ====
`timescale 1ns/10ps
`include "fb_cfg.svh"

module frame_buffer_top (
  input  logic                      sdram_clk,
  input  logic                      sys_rst_n,
  input  fb_pkg::line_req_t         line_req,
  output logic                      line_ack,
  input  fb_pkg::page_req_t         page_req,
  output logic                      page_ack,
  input  fb_pkg::stage_wr_t         stage_wr,
  input  fb_pkg::host_wr_t          host_wr,
  output logic                      host_ack,
  input  logic [`FB_PIX_ADDR_W-1:0] pix_addr,
  output fb_pkg::pixel_t            pix_a_data,
  output fb_pkg::pixel_t            pix_b_data,
  output fb_pkg::mem_req_t          mem_req,
  input  logic                      mem_ack,
  output fb_pkg::pixel_t            mem_wdata,
  input  fb_pkg::pixel_t            mem_rdata,
  output logic                      busy
);
  import fb_pkg::*;

  mem_req_t line_mem;   // line fetch burst request
  mem_req_t page_mem;   // page / single write burst request
  logic     line_gack;
  logic     page_gack;
  logic     line_active;
  logic     page_active;

  line_fetch line_fetch_inst (
    .sdram_clk  (sdram_clk),
    .sys_rst_n  (sys_rst_n),
    .line_req   (line_req),
    .line_ack   (line_ack),
    .mem_req    (line_mem),
    .mem_ack    (line_gack),
    .mem_rdata  (mem_rdata),  // only the line fetch reads
    .pix_addr   (pix_addr),
    .pix_a_data (pix_a_data),
    .pix_b_data (pix_b_data),
    .active     (line_active)
  );

  page_write page_write_inst (
    .sdram_clk (sdram_clk),
    .sys_rst_n (sys_rst_n),
    .stage_wr  (stage_wr),
    .page_req  (page_req),
    .page_ack  (page_ack),
    .host_wr   (host_wr),
    .host_ack  (host_ack),
    .mem_req   (page_mem),
    .mem_ack   (page_gack),
    .mem_wdata (mem_wdata),   // sole writer on the port
    .active    (page_active)
  );

  burst_arbiter burst_arbiter_inst (
    .sdram_clk      (sdram_clk),
    .sys_rst_n      (sys_rst_n),
    .line_mem       (line_mem),
    .page_mem       (page_mem),
    .line_grant_ack (line_gack),
    .page_grant_ack (page_gack),
    .mem_req        (mem_req),
    .mem_ack        (mem_ack)
  );

  assign busy = line_active | page_active;

endmodule

// ==== hw/burst_arbiter.sv ====
`timescale 1ns/10ps

module burst_arbiter (
  input  logic             sdram_clk,
  input  logic             sys_rst_n,
  input  fb_pkg::mem_req_t line_mem,
  input  fb_pkg::mem_req_t page_mem,
  output logic             line_grant_ack,
  output logic             page_grant_ack,
  output fb_pkg::mem_req_t mem_req,
  input  logic             mem_ack
);

  typedef enum logic [1:0] {GR_NONE, GR_LINE, GR_PAGE} grant_t;

  grant_t grant;
  grant_t grant_nxt;
  logic   holder_busy;

  // the holder keeps the port until it drops valid
  assign holder_busy = (grant == GR_LINE && line_mem.valid) ||
                       (grant == GR_PAGE && page_mem.valid);

  always_comb begin
    grant_nxt = grant;
    if (!holder_busy) begin
      if (line_mem.valid) begin
        grant_nxt = GR_LINE;  // display first
      end else if (page_mem.valid) begin
        grant_nxt = GR_PAGE;
      end else begin
        grant_nxt = GR_NONE;
      end
    end
  end

  always_ff @(posedge sdram_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      grant <= GR_NONE;
    end else begin
      grant <= grant_nxt;
    end
  end

  always_comb begin
    case (grant)
      GR_LINE: mem_req = line_mem;
      GR_PAGE: mem_req = page_mem;
      default: mem_req = '0;
    endcase
  end

  // only the grant holder sees acks
  assign line_grant_ack = mem_ack && (grant == GR_LINE);
  assign page_grant_ack = mem_ack && (grant == GR_PAGE);

endmodule

// ==== hw/page_write.sv ====
`timescale 1ns/10ps
`include "fb_cfg.svh"

module page_write (
  input  logic               sdram_clk,
  input  logic               sys_rst_n,
  input  fb_pkg::stage_wr_t  stage_wr,
  input  fb_pkg::page_req_t  page_req,
  output logic               page_ack,
  input  fb_pkg::host_wr_t   host_wr,
  output logic               host_ack,
  output fb_pkg::mem_req_t   mem_req,
  input  logic               mem_ack,
  output fb_pkg::pixel_t     mem_wdata,
  output logic               active
);
  import fb_pkg::*;

  localparam int WORD_W = $clog2(`FB_BURST_LEN);

  typedef enum logic [2:0] {ST_IDLE, ST_PAGE, ST_HOST, ST_PDONE, ST_HDONE} state_t;

  state_t                state;
  logic [WORD_W-1:0]     word;
  logic [WORD_W-1:0]     stage_raddr;
  pixel_t                stage_rdata;
  logic [`FB_PAGE_W-1:0] page_q;
  logic [`FB_ADDR_W-1:0] haddr_q;
  pixel_t                hdata_q;

  // read one word ahead on each ack so the registered output holds the word due next
  assign stage_raddr = (state == ST_PAGE && mem_ack) ? word + 1'b1 : word;

  line_buffer #(.DEPTH(`FB_BURST_LEN)) stage_inst (
    .sdram_clk (sdram_clk),
    .we        (stage_wr.en),
    .waddr     (stage_wr.idx),
    .wdata     (stage_wr.data),
    .raddr     (stage_raddr),
    .rdata     (stage_rdata)
  );

  always_ff @(posedge sdram_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state   <= ST_IDLE;
      word    <= '0;
      page_q  <= '0;
      haddr_q <= '0;
      hdata_q <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          word <= '0;
          if (page_req.req) begin
            page_q <= page_req.page;
            state  <= ST_PAGE;
          end else if (host_wr.req) begin
            haddr_q <= host_wr.addr;
            hdata_q <= host_wr.data;
            state   <= ST_HOST;
          end
        end
        ST_PAGE: begin
          if (mem_ack) begin
            word <= word + 1'b1;
            if (word == WORD_W'(`FB_BURST_LEN - 1)) begin
              state <= ST_PDONE;
            end
          end
        end
        ST_HOST: begin
          if (mem_ack) begin
            state <= ST_HDONE;
          end
        end
        ST_PDONE: begin
          if (!page_req.req) begin
            state <= ST_IDLE;
          end
        end
        ST_HDONE: begin
          if (!host_wr.req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    mem_req.valid = (state == ST_PAGE) || (state == ST_HOST);
    mem_req.write = 1'b1;
    if (state == ST_HOST) begin
      mem_req.addr = haddr_q;
      mem_req.len  = burst_len_t'(1);
      mem_wdata    = hdata_q;
    end else begin
      mem_req.addr = {page_q, {WORD_W{1'b0}}};
      mem_req.len  = burst_len_t'(`FB_BURST_LEN);
      mem_wdata    = stage_rdata;
    end
  end

  assign page_ack = (state == ST_PDONE);
  assign host_ack = (state == ST_HDONE);
  assign active   = (state == ST_PAGE) || (state == ST_HOST);

endmodule

// ==== hw/line_fetch.sv ====
`timescale 1ns/10ps
`include "fb_cfg.svh"

module line_fetch (
  input  logic                      sdram_clk,
  input  logic                      sys_rst_n,
  input  fb_pkg::line_req_t         line_req,
  output logic                      line_ack,
  output fb_pkg::mem_req_t          mem_req,
  input  logic                      mem_ack,
  input  fb_pkg::pixel_t            mem_rdata,
  input  logic [`FB_PIX_ADDR_W-1:0] pix_addr,
  output fb_pkg::pixel_t            pix_a_data,
  output fb_pkg::pixel_t            pix_b_data,
  output logic                      active
);
  import fb_pkg::*;

  localparam int SEG_W  = $clog2(`FB_LINE_SEGS);
  localparam int WORD_W = $clog2(`FB_BURST_LEN);
  localparam int DEPTH  = `FB_LINE_SEGS * `FB_BURST_LEN;

  typedef enum logic [1:0] {ST_IDLE, ST_BURST, ST_GAP, ST_DONE} state_t;

  state_t                  state;
  line_req_t               req_q;  // line and buffer of the running fetch
  logic [SEG_W-1:0]        seg;
  logic [WORD_W-1:0]       word;
  logic                    last_word;
  logic                    wr_a;
  logic                    wr_b;
  logic [SEG_W+WORD_W-1:0] waddr;

  assign last_word = mem_ack && (word == WORD_W'(`FB_BURST_LEN - 1));

  always_ff @(posedge sdram_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state <= ST_IDLE;
      seg   <= '0;
      word  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (line_req.req) begin
            state <= ST_BURST;
            seg   <= '0;
            word  <= '0;
          end
        end
        ST_BURST: begin
          if (mem_ack) begin
            word <= word + 1'b1;  // wraps to 0 after the last word
          end
          if (last_word) begin
            if (seg == SEG_W'(`FB_LINE_SEGS - 1)) begin
              state <= ST_DONE;
            end else begin
              seg   <= seg + 1'b1;
              state <= ST_GAP;  // drop valid so the arbiter can release
            end
          end
        end
        ST_GAP:  state <= ST_BURST;
        ST_DONE: begin
          if (!line_req.req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge sdram_clk) begin
    if (state == ST_IDLE && line_req.req) begin
      req_q <= line_req;  // sampled at start
    end
  end

  always_comb begin
    mem_req.valid = (state == ST_BURST);
    mem_req.write = 1'b0;
    mem_req.addr  = {req_q.line, seg, {WORD_W{1'b0}}};
    mem_req.len   = burst_len_t'(`FB_BURST_LEN);
  end

  assign line_ack = (state == ST_DONE);
  assign active   = (state == ST_BURST) || (state == ST_GAP);

  // each received word goes straight into the selected buffer
  assign wr_a  = (state == ST_BURST) && mem_ack && req_q.buf_a;
  assign wr_b  = (state == ST_BURST) && mem_ack && !req_q.buf_a;
  assign waddr = {seg, word};

  line_buffer #(.DEPTH(DEPTH)) buf_a_inst (
    .sdram_clk (sdram_clk),
    .we        (wr_a),
    .waddr     (waddr),
    .wdata     (mem_rdata),
    .raddr     (pix_addr),
    .rdata     (pix_a_data)
  );

  line_buffer #(.DEPTH(DEPTH)) buf_b_inst (
    .sdram_clk (sdram_clk),
    .we        (wr_b),
    .waddr     (waddr),
    .wdata     (mem_rdata),
    .raddr     (pix_addr),  // display reads one buffer while the other fills
    .rdata     (pix_b_data)
  );

endmodule

// ==== hw/line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer #(
  parameter int DEPTH = 1024
) (
  input  logic                     sdram_clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  fb_pkg::pixel_t           wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output fb_pkg::pixel_t           rdata
);
  import fb_pkg::*;

  pixel_t mem [DEPTH];

  always_ff @(posedge sdram_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // registered, one cycle latency
  end

endmodule

// ==== hw/fb_pkg.sv ====
`include "fb_cfg.svh"

package fb_pkg;

  typedef logic [15:0] pixel_t;                          // one sdram word
  typedef logic [$clog2(`FB_BURST_LEN):0] burst_len_t;   // 1 to 256 words

  // one burst on the controller port
  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [`FB_ADDR_W-1:0] addr;
    burst_len_t            len;
  } mem_req_t;

  typedef struct packed {
    logic                  req;
    logic [`FB_LINE_W-1:0] line;
    logic                  buf_a;  // 1 selects buffer a
  } line_req_t;

  typedef struct packed {
    logic                  req;
    logic [`FB_PAGE_W-1:0] page;
  } page_req_t;

  typedef struct packed {
    logic                  req;
    logic [`FB_ADDR_W-1:0] addr;
    pixel_t                data;
  } host_wr_t;

  typedef struct packed {
    logic                  en;
    logic [7:0]            idx;    // word within the staged page
    pixel_t                data;
  } stage_wr_t;

endpackage

// ==== hw/fb_cfg.svh ====
`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// 1024 x 1024 words x 4 frames
`define FB_ADDR_W     22
`define FB_LINE_W     12  // display line number
`define FB_PAGE_W     14  // dma page number

`define FB_BURST_LEN  256 // words per burst
`define FB_LINE_SEGS  4   // bursts per display line
`define FB_PIX_ADDR_W 10  // pixel index within a line

`endif
